// ==== src/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// pc after reset
`define CORE_RESET_VECTOR 32'h8000_0000

// RV32E register count
`define CORE_NUM_REGS 16

// mstatus with MPP = machine mode
`define CORE_MSTATUS_RESET 32'h0000_1800

// mcause code for environment call from M-mode
`define CORE_ECALL_CAUSE 32'd11

`endif

// ==== src/isa_pkg.sv ====
package isa_pkg;

    // plain data and address word
    typedef logic [31:0] word_t;

    // raw instruction
    typedef logic [31:0] inst_t;

    // RV32E register index
    typedef logic [3:0] reg_addr_t;

    // csr address field
    typedef logic [11:0] csr_addr_t;

    // funct3 field, also the branch condition
    typedef logic [2:0] funct3_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // implemented machine csrs
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_e;

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {OPB_REG, OPB_IMM} opb_sel_e;

    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} opa_sel_e;

    // write-back source
    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_CSR} wb_sel_e;

    // next pc kind
    typedef enum logic [2:0] {
        NPC_SEQ,
        NPC_BRANCH,
        NPC_JAL,
        NPC_JALR,
        NPC_TRAP,
        NPC_MRET
    } npc_sel_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_cmd_e;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t      inst,
    output isa_pkg::reg_addr_t  rs1_addr,
    output isa_pkg::reg_addr_t  rs2_addr,
    output isa_pkg::reg_addr_t  rd_addr,
    output logic                rd_wen,
    output isa_pkg::word_t      imm,
    output ctrl_pkg::alu_op_e   alu_op,
    output ctrl_pkg::opa_sel_e  opa_sel,
    output ctrl_pkg::opb_sel_e  opb_sel,
    output ctrl_pkg::wb_sel_e   wb_sel,
    output ctrl_pkg::npc_sel_e  npc_sel,
    output isa_pkg::funct3_t    branch_funct,
    output ctrl_pkg::csr_cmd_e  csr_cmd,
    output isa_pkg::csr_addr_t  csr_addr,
    output logic                trap,
    output logic                mret
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::funct3_t  funct3;
    isa_pkg::word_t    imm_i;
    isa_pkg::word_t    imm_b;
    isa_pkg::word_t    imm_u;
    isa_pkg::word_t    imm_j;
    logic              writes_rd;
    logic              rs1_zero;

    // arithmetic op from funct3, inst[30] picks sub/sra
    function automatic ctrl_pkg::alu_op_e alu_decode(
        input isa_pkg::funct3_t f3,
        input logic             alt,
        input logic             is_reg
    );
        ctrl_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
            3'b001:  op = ctrl_pkg::ALU_SLL;
            3'b010:  op = ctrl_pkg::ALU_SLT;
            3'b011:  op = ctrl_pkg::ALU_SLTU;
            3'b100:  op = ctrl_pkg::ALU_XOR;
            3'b101:  op = alt ? ctrl_pkg::ALU_SRA : ctrl_pkg::ALU_SRL;
            3'b110:  op = ctrl_pkg::ALU_OR;
            default: op = ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = isa_pkg::opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign rd_addr  = inst[10:7];
    assign rs1_addr = inst[18:15];
    assign rs2_addr = inst[23:20];
    assign csr_addr = inst[31:20];
    assign rs1_zero = (rs1_addr == '0);

    assign branch_funct = funct3;

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // x0 never gets a write enable
    assign rd_wen = writes_rd && (rd_addr != '0);

    always_comb begin
        // defaults give a sequential nop
        writes_rd = 1'b0;
        imm       = imm_i;
        alu_op    = ctrl_pkg::ALU_PASS_B;
        opa_sel   = ctrl_pkg::OPA_REG;
        opb_sel   = ctrl_pkg::OPB_IMM;
        wb_sel    = ctrl_pkg::WB_ALU;
        npc_sel   = ctrl_pkg::NPC_SEQ;
        csr_cmd   = ctrl_pkg::CSR_NONE;
        trap      = 1'b0;
        mret      = 1'b0;

        case (opcode)
            isa_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                opb_sel   = ctrl_pkg::OPB_REG;
                alu_op    = alu_decode(funct3, inst[30], 1'b1);
            end
            isa_pkg::OPC_OP_IMM: begin
                writes_rd = 1'b1;
                alu_op    = alu_decode(funct3, inst[30], 1'b0);
            end
            isa_pkg::OPC_LUI: begin
                writes_rd = 1'b1;
                imm       = imm_u;
                opa_sel   = ctrl_pkg::OPA_ZERO;
                alu_op    = ctrl_pkg::ALU_ADD;
            end
            isa_pkg::OPC_AUIPC: begin
                writes_rd = 1'b1;
                imm       = imm_u;
                opa_sel   = ctrl_pkg::OPA_PC;
                alu_op    = ctrl_pkg::ALU_ADD;
            end
            isa_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                imm       = imm_j;
                wb_sel    = ctrl_pkg::WB_PC4;
                npc_sel   = ctrl_pkg::NPC_JAL;
            end
            isa_pkg::OPC_JALR: begin
                writes_rd = 1'b1;
                wb_sel    = ctrl_pkg::WB_PC4;
                npc_sel   = ctrl_pkg::NPC_JALR;
            end
            isa_pkg::OPC_BRANCH: begin
                imm     = imm_b;
                npc_sel = ctrl_pkg::NPC_BRANCH;
            end
            isa_pkg::OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        if (inst[31:20] == 12'h000) begin
                            trap    = 1'b1;
                            npc_sel = ctrl_pkg::NPC_TRAP;
                        end else if (inst[31:20] == 12'h302) begin
                            mret    = 1'b1;
                            npc_sel = ctrl_pkg::NPC_MRET;
                        end
                    end
                    3'b001: begin
                        writes_rd = 1'b1;
                        wb_sel    = ctrl_pkg::WB_CSR;
                        csr_cmd   = ctrl_pkg::CSR_WRITE;
                    end
                    // rs1 = x0 turns set/clear into a plain read
                    3'b010: begin
                        writes_rd = 1'b1;
                        wb_sel    = ctrl_pkg::WB_CSR;
                        csr_cmd   = rs1_zero ? ctrl_pkg::CSR_NONE : ctrl_pkg::CSR_SET;
                    end
                    3'b011: begin
                        writes_rd = 1'b1;
                        wb_sel    = ctrl_pkg::WB_CSR;
                        csr_cmd   = rs1_zero ? ctrl_pkg::CSR_NONE : ctrl_pkg::CSR_CLEAR;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

`include "core_defines.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2,
    input  logic                wen,
    input  isa_pkg::reg_addr_t  waddr,
    input  isa_pkg::word_t      wdata
);

    isa_pkg::word_t regs [`CORE_NUM_REGS];

    // decoder already drops writes to x0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

`include "core_defines.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst,
    input  ctrl_pkg::csr_cmd_e  cmd,
    input  isa_pkg::csr_addr_t  addr,
    input  isa_pkg::word_t      operand,
    output isa_pkg::word_t      rdata,
    input  logic                trap,
    input  logic                mret,
    input  isa_pkg::word_t      pc,
    output isa_pkg::word_t      trap_vector,
    output isa_pkg::word_t      return_pc
);

    isa_pkg::word_t mstatus;
    isa_pkg::word_t mtvec;
    isa_pkg::word_t mepc;
    isa_pkg::word_t mcause;
    isa_pkg::word_t wdata;
    logic           wen;

    // old value of the addressed csr, unknown ones read zero
    always_comb begin
        case (addr)
            isa_pkg::CSR_MSTATUS: rdata = mstatus;
            isa_pkg::CSR_MTVEC:   rdata = mtvec;
            isa_pkg::CSR_MEPC:    rdata = mepc;
            isa_pkg::CSR_MCAUSE:  rdata = mcause;
            default:              rdata = '0;
        endcase
    end

    always_comb begin
        case (cmd)
            ctrl_pkg::CSR_WRITE: wdata = operand;
            ctrl_pkg::CSR_SET:   wdata = rdata | operand;
            ctrl_pkg::CSR_CLEAR: wdata = rdata & ~operand;
            default:             wdata = rdata;
        endcase
    end

    // trap and return never carry a csr command
    assign wen = (cmd != ctrl_pkg::CSR_NONE) && !trap && !mret;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= `CORE_MSTATUS_RESET;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap) begin
            mepc   <= pc;
            mcause <= `CORE_ECALL_CAUSE;
        end else if (wen) begin
            case (addr)
                isa_pkg::CSR_MSTATUS: mstatus <= wdata;
                isa_pkg::CSR_MTVEC:   mtvec   <= wdata;
                isa_pkg::CSR_MEPC:    mepc    <= wdata;
                isa_pkg::CSR_MCAUSE:  mcause  <= wdata;
                default: ;
            endcase
        end
    end

    // direct mode only, low two bits are not part of the target
    assign trap_vector = {mtvec[31:2], 2'b00};
    assign return_pc   = {mepc[31:2], 2'b00};

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

`include "core_defines.svh"

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    output isa_pkg::word_t      pc,
    input  isa_pkg::word_t      rs1_data,
    input  isa_pkg::word_t      rs2_data,
    input  isa_pkg::word_t      imm,
    input  ctrl_pkg::alu_op_e   alu_op,
    input  ctrl_pkg::opa_sel_e  opa_sel,
    input  ctrl_pkg::opb_sel_e  opb_sel,
    input  ctrl_pkg::wb_sel_e   wb_sel,
    input  ctrl_pkg::npc_sel_e  npc_sel,
    input  isa_pkg::funct3_t    branch_funct,
    input  isa_pkg::word_t      csr_rdata,
    input  isa_pkg::word_t      trap_vector,
    input  isa_pkg::word_t      return_pc,
    output isa_pkg::word_t      wb_data
);

    isa_pkg::word_t opa;
    isa_pkg::word_t opb;
    isa_pkg::word_t alu_res;
    isa_pkg::word_t pc_plus4;
    isa_pkg::word_t next_pc;
    logic [4:0]     shamt;
    logic           taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (opa_sel)
            ctrl_pkg::OPA_PC:   opa = pc;
            ctrl_pkg::OPA_ZERO: opa = '0;
            default:            opa = rs1_data;
        endcase
    end

    assign opb   = (opb_sel == ctrl_pkg::OPB_IMM) ? imm : rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (alu_op)
            ctrl_pkg::ALU_ADD:  alu_res = opa + opb;
            ctrl_pkg::ALU_SUB:  alu_res = opa - opb;
            ctrl_pkg::ALU_SLL:  alu_res = opa << shamt;
            ctrl_pkg::ALU_SLT:  alu_res = {31'b0, $signed(opa) < $signed(opb)};
            ctrl_pkg::ALU_SLTU: alu_res = {31'b0, opa < opb};
            ctrl_pkg::ALU_XOR:  alu_res = opa ^ opb;
            ctrl_pkg::ALU_SRL:  alu_res = opa >> shamt;
            ctrl_pkg::ALU_SRA:  alu_res = $unsigned($signed(opa) >>> shamt);
            ctrl_pkg::ALU_OR:   alu_res = opa | opb;
            ctrl_pkg::ALU_AND:  alu_res = opa & opb;
            default:            alu_res = opb;
        endcase
    end

    // branch condition, reserved funct3 codes never branch
    always_comb begin
        case (branch_funct)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (npc_sel)
            ctrl_pkg::NPC_BRANCH: next_pc = taken ? pc + imm : pc_plus4;
            ctrl_pkg::NPC_JAL:    next_pc = pc + imm;
            ctrl_pkg::NPC_JALR:   next_pc = (rs1_data + imm) & ~32'd1;
            ctrl_pkg::NPC_TRAP:   next_pc = trap_vector;
            ctrl_pkg::NPC_MRET:   next_pc = return_pc;
            default:              next_pc = pc_plus4;
        endcase
    end

    // one instruction retires per edge
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_VECTOR;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        case (wb_sel)
            ctrl_pkg::WB_PC4: wb_data = pc_plus4;
            ctrl_pkg::WB_CSR: wb_data = csr_rdata;
            default:          wb_data = alu_res;
        endcase
    end

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                clk,
    input  logic                rst,
    output isa_pkg::word_t      pc,
    input  isa_pkg::inst_t      inst,
    output logic                wb_en,
    output isa_pkg::reg_addr_t  wb_addr,
    output isa_pkg::word_t      wb_data
);

    isa_pkg::reg_addr_t  rs1_addr;
    isa_pkg::reg_addr_t  rs2_addr;
    isa_pkg::reg_addr_t  rd_addr;
    logic                rd_wen;
    isa_pkg::word_t      imm;
    ctrl_pkg::alu_op_e   alu_op;
    ctrl_pkg::opa_sel_e  opa_sel;
    ctrl_pkg::opb_sel_e  opb_sel;
    ctrl_pkg::wb_sel_e   wb_sel;
    ctrl_pkg::npc_sel_e  npc_sel;
    isa_pkg::funct3_t    branch_funct;
    ctrl_pkg::csr_cmd_e  csr_cmd;
    isa_pkg::csr_addr_t  csr_addr;
    logic                trap;
    logic                mret;
    isa_pkg::word_t      rs1_data;
    isa_pkg::word_t      rs2_data;
    isa_pkg::word_t      csr_rdata;
    isa_pkg::word_t      trap_vector;
    isa_pkg::word_t      return_pc;

    inst_decoder u_dec (
        .inst         (inst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .rd_wen       (rd_wen),
        .imm          (imm),
        .alu_op       (alu_op),
        .opa_sel      (opa_sel),
        .opb_sel      (opb_sel),
        .wb_sel       (wb_sel),
        .npc_sel      (npc_sel),
        .branch_funct (branch_funct),
        .csr_cmd      (csr_cmd),
        .csr_addr     (csr_addr),
        .trap         (trap),
        .mret         (mret)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (rd_wen),
        .waddr  (rd_addr),
        .wdata  (wb_data)
    );

    // csr operand comes straight from rs1
    csr_file u_csr (
        .clk         (clk),
        .rst         (rst),
        .cmd         (csr_cmd),
        .addr        (csr_addr),
        .operand     (rs1_data),
        .rdata       (csr_rdata),
        .trap        (trap),
        .mret        (mret),
        .pc          (pc),
        .trap_vector (trap_vector),
        .return_pc   (return_pc)
    );

    exec_unit u_exec (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .alu_op       (alu_op),
        .opa_sel      (opa_sel),
        .opb_sel      (opb_sel),
        .wb_sel       (wb_sel),
        .npc_sel      (npc_sel),
        .branch_funct (branch_funct),
        .csr_rdata    (csr_rdata),
        .trap_vector  (trap_vector),
        .return_pc    (return_pc),
        .wb_data      (wb_data)
    );

    // retirement trace
    assign wb_en   = rd_wen && !rst;
    assign wb_addr = rd_addr;

endmodule

// ==== verification/core_checker.sv ====
`timescale 1ns/1ps

`include "core_defines.svh"

module core_checker (
    input logic               clk,
    input logic               rst,
    input isa_pkg::word_t     pc,
    input logic               wb_en,
    input isa_pkg::reg_addr_t wb_addr
);

    // failed property count
    int unsigned fail_count = 0;

    // pc reloads the reset vector
    reset_vector_a: assert property (@(posedge clk) rst |=> (pc == `CORE_RESET_VECTOR))
        else begin
            $error("pc is not the reset vector after reset");
            fail_count++;
        end

    pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            fail_count++;
        end

    // x0 never shows up in the trace
    wb_addr_nonzero_a: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_addr != '0)
        else begin
            $error("write-back reported for x0");
            fail_count++;
        end

    wb_quiet_in_reset_a: assert property (@(posedge clk) rst |-> !wb_en)
        else begin
            $error("write-back reported during reset");
            fail_count++;
        end

endmodule

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps

`include "core_defines.svh"

module core_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTS    = 2000;
    localparam int MAX_TRAPS    = 40;

    logic               clk;
    logic               rst;
    isa_pkg::inst_t     inst;
    isa_pkg::word_t     pc;
    logic               wb_en;
    isa_pkg::reg_addr_t wb_addr;
    isa_pkg::word_t     wb_data;

    // reference model state
    isa_pkg::word_t m_regs [`CORE_NUM_REGS];
    isa_pkg::word_t m_pc;
    isa_pkg::word_t m_mstatus;
    isa_pkg::word_t m_mtvec;
    isa_pkg::word_t m_mepc;
    isa_pkg::word_t m_mcause;
    logic [31:0]    rng;
    int             n_ecall;
    int             n_mret;

    core_top UUT (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .inst    (inst),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    bind core_top core_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                               input isa_pkg::word_t a, input isa_pkg::word_t b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input isa_pkg::word_t a,
                                          input isa_pkg::word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic isa_pkg::word_t csr_read(input logic [11:0] addr);
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            default: return '0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input isa_pkg::word_t v);
        case (addr)
            12'h300: m_mstatus = v;
            12'h305: m_mtvec   = v;
            12'h341: m_mepc    = v;
            12'h342: m_mcause  = v;
            default: ;
        endcase
    endtask

    // random instruction built from the model's current registers
    function automatic isa_pkg::inst_t gen_inst();
        logic [31:0]    r;
        logic [31:0]    s;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [2:0]     f3;
        logic [11:0]    imm;
        logic [12:0]    boff;
        logic [20:0]    joff;
        logic [11:0]    csr;
        isa_pkg::inst_t i;
        r    = rand_word();
        s    = rand_word();
        rd   = {1'b0, r[3:0]};
        rs1  = {1'b0, r[7:4]};
        // equal operands now and then so beq/bge get taken
        rs2  = s[8] ? rs1 : {1'b0, r[11:8]};
        f3   = r[14:12];
        imm  = r[27:16];
        boff = {{6{s[6]}}, s[6:2], 2'b00};
        joff = {{10{s[10]}}, s[10:2], 2'b00};
        i    = 32'h0000_0013;
        case (s[31:28])
            4'd0, 4'd1, 4'd2:
                i = {1'b0, r[31] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            4'd3, 4'd4, 4'd5: begin
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, r[31] && f3 == 3'd5, 5'b0, r[20:16]};
                i = {imm, rs1, f3, rd, 7'b0010011};
            end
            4'd6:    i = {r[31:12], rd, 7'b0110111};
            4'd7:    i = {r[31:12], rd, 7'b0010111};
            4'd8, 4'd9: begin
                // reserved funct3 2 and 3 fold onto bltu/bgeu
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                i = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
            end
            4'd10:   i = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
            4'd11: begin
                // rs1 + imm lands on a word with bit 0 sometimes set
                imm = {{3{s[9]}}, s[9:3], 2'b00} - m_regs[rs1[3:0]][1:0] + s[0];
                i = {imm, rs1, 3'b000, rd, 7'b1100111};
            end
            4'd12, 4'd13: begin
                f3 = (s[1:0] == 2'b00) ? 3'd1 : {1'b0, s[1:0]};
                if (s[13:12] == 2'b00) rs1 = '0;
                case (s[17:15])
                    3'd0:       csr = isa_pkg::CSR_MSTATUS;
                    3'd1, 3'd2: csr = isa_pkg::CSR_MTVEC;
                    3'd3, 3'd4: csr = isa_pkg::CSR_MEPC;
                    3'd5, 3'd6: csr = isa_pkg::CSR_MCAUSE;
                    default:    csr = 12'h340;
                endcase
                i = {csr, rs1, f3, rd, 7'b1110011};
            end
            4'd14: begin
                if (s[0] && n_ecall < MAX_TRAPS) begin
                    i = 32'h0000_0073;
                    n_ecall++;
                end else if (!s[0] && n_mret < MAX_TRAPS) begin
                    i = 32'h3020_0073;
                    n_mret++;
                end
            end
            default: begin
                case (s[1:0])
                    2'd0:    i = {r[31:7], 7'b0000011};
                    2'd1:    i = {r[31:7], 7'b0100011};
                    2'd2:    i = {r[31:7], 7'b0001111};
                    default: i = {r[31:7], 7'b1111111};
                endcase
            end
        endcase
        return i;
    endfunction

    // one instruction on the model and its expected trace
    task automatic run_model(input isa_pkg::inst_t i, output logic wen,
                             output isa_pkg::word_t wdata);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm_i;
        isa_pkg::word_t imm_b;
        isa_pkg::word_t imm_j;
        isa_pkg::word_t old;
        isa_pkg::word_t upd;
        isa_pkg::word_t next;
        logic           writes;
        logic [2:0]     f3;
        f3     = i[14:12];
        a      = m_regs[i[18:15]];
        b      = m_regs[i[23:20]];
        imm_i  = {{20{i[31]}}, i[31:20]};
        imm_b  = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_j  = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        next   = m_pc + 32'd4;
        writes = 1'b1;
        wdata  = '0;
        case (i[6:0])
            7'b0110011: wdata = alu_ref(f3, i[30], a, b);
            7'b0010011: wdata = alu_ref(f3, f3 == 3'd5 && i[30], a, imm_i);
            7'b0110111: wdata = {i[31:12], 12'b0};
            7'b0010111: wdata = m_pc + {i[31:12], 12'b0};
            7'b1101111: begin
                wdata = m_pc + 32'd4;
                next  = m_pc + imm_j;
            end
            7'b1100111: begin
                wdata = m_pc + 32'd4;
                next  = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                writes = 1'b0;
                if (branch_taken(f3, a, b)) next = m_pc + imm_b;
            end
            7'b1110011: begin
                if (f3 == 3'd0) begin
                    writes = 1'b0;
                    // direct trap mode with word aligned targets
                    if (i[31:20] == 12'h000) begin
                        next     = {m_mtvec[31:2], 2'b00};
                        m_mepc   = m_pc;
                        m_mcause = `CORE_ECALL_CAUSE;
                    end else if (i[31:20] == 12'h302) begin
                        next = {m_mepc[31:2], 2'b00};
                    end
                end else begin
                    old   = csr_read(i[31:20]);
                    wdata = old;
                    case (f3)
                        3'd1:    upd = a;
                        3'd2:    upd = old | a;
                        default: upd = old & ~a;
                    endcase
                    if (f3 == 3'd1 || i[18:15] != 4'd0) csr_write(i[31:20], upd);
                end
            end
            default: writes = 1'b0;
        endcase
        wen = writes && (i[10:7] != 4'd0);
        if (wen) m_regs[i[10:7]] = wdata;
        m_pc = next;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value check failed");
        end
    endtask

    initial begin
        #((RESET_CYCLES + NUM_INSTS + 20) * CLK_PERIOD);
        $display("ERROR: watchdog expired before all instructions retired");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        isa_pkg::inst_t cur;
        logic           exp_wen;
        isa_pkg::word_t exp_wdata;
        rng       = 32'h11ae_1286;
        n_ecall   = 0;
        n_mret    = 0;
        m_pc      = `CORE_RESET_VECTOR;
        m_mstatus = `CORE_MSTATUS_RESET;
        m_mtvec   = '0;
        m_mepc    = '0;
        m_mcause  = '0;
        for (int k = 0; k < `CORE_NUM_REGS; k++) begin
            m_regs[k] = '0;
        end
        rst  = 1'b1;
        // addi x1 held during reset must neither retire nor show in the trace
        inst = 32'h0010_0093;
        repeat (RESET_CYCLES) @(posedge clk);
        cur = gen_inst();
        rst  <= 1'b0;
        inst <= cur;
        for (int n = 0; n < NUM_INSTS; n++) begin
            // outputs settle by the falling edge
            @(negedge clk);
            check_word("pc", pc, m_pc);
            run_model(cur, exp_wen, exp_wdata);
            check_word("wb_en", wb_en, exp_wen);
            if (exp_wen) begin
                check_word("wb_addr", wb_addr, cur[10:7]);
                check_word("wb_data", wb_data, exp_wdata);
            end
            @(posedge clk);
            cur = gen_inst();
            inst <= cur;
        end
        @(negedge clk);
        check_word("pc", pc, m_pc);
        if (UUT.u_checker.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/csr_file.sv
src/exec_unit.sv
src/core_top.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32e_core

export_include_dirs:
  - src

sources:
  - src/isa_pkg.sv
  - src/ctrl_pkg.sv
  - src/inst_decoder.sv
  - src/reg_file.sv
  - src/csr_file.sv
  - src/exec_unit.sv
  - src/core_top.sv
  - target: test
    files:
      - verification/core_checker.sv
      - verification/core_tb.sv
